// File: Makefile
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f all.f --top-module drive_top_tb
	verilator --lint-only -f all.f --top-module drive_top

sim:
	verilator --binary --timing -f all.f --top-module drive_top_tb -o drive_sim
	out=$$(./obj_dir/drive_sim); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

// File: all.f
cpu_bus_pkg.sv
drive_pkg.sv
cpu_bus_decoder.sv
ctl_reg_file.sv
mod_mem.sv
duty_phase_mem.sv
mod_sequencer.sv
drive_top.sv
tb_clock_gen.sv
drive_top_tb.sv

// File: cpu_bus_decoder.sv
`timescale 1ns/100ps
module cpu_bus_decoder (
  input  logic                            CPU_CKIO,
  input  logic                            arst_n,
  input  logic                            cpu_cs_n,
  input  logic                            cpu_we_n,
  input  logic [cpu_bus_pkg::CPU_ADDR_W-1:0] cpu_addr,
  input  cpu_bus_pkg::cpu_data_t          cpu_data_in,
  input  cpu_bus_pkg::cpu_data_t          ctl_rd_data,
  output cpu_bus_pkg::cpu_data_t          cpu_data_out,
  output logic                            ctl_we,
  output logic                            mod_we,
  output logic                            normal_we,
  output cpu_bus_pkg::bank_addr_t         wr_addr,
  output cpu_bus_pkg::cpu_data_t          wr_data,
  output cpu_bus_pkg::bank_addr_t         rd_addr
);

  logic                            cs_n_q;
  logic                            we_n_q;
  logic                            we_n_d;
  logic [cpu_bus_pkg::CPU_ADDR_W-1:0] addr_q;
  cpu_bus_pkg::cpu_data_t          data_q;
  cpu_bus_pkg::bank_sel_t          bank_sel;
  logic                            wr_fire;
  logic                            ctl_hit;
  logic                            mod_hit;
  logic                            normal_hit;

  // the bus is asynchronous to CPU_CKIO, so everything is sampled once first
  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      cs_n_q <= 1'b1;
      we_n_q <= 1'b1;
      we_n_d <= 1'b1;
    end else begin
      cs_n_q <= cpu_cs_n;
      we_n_q <= cpu_we_n;
      we_n_d <= we_n_q;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr;
    data_q <= cpu_data_in;
  end

  assign bank_sel = addr_q[cpu_bus_pkg::CPU_ADDR_W-1:cpu_bus_pkg::BANK_ADDR_W];
  assign rd_addr = addr_q[cpu_bus_pkg::BANK_ADDR_W-1:0];

  // one write per falling edge of the sampled write enable
  assign wr_fire = ~cs_n_q & ~we_n_q & we_n_d;

  always_comb begin
    ctl_hit = 1'b0;
    mod_hit = 1'b0;
    normal_hit = 1'b0;
    case (bank_sel)
      cpu_bus_pkg::BANK_CONTROLLER: ctl_hit = 1'b1;
      cpu_bus_pkg::BANK_MOD: mod_hit = 1'b1;
      cpu_bus_pkg::BANK_NORMAL: normal_hit = 1'b1;
      // writes to the STM bank are dropped
      cpu_bus_pkg::BANK_STM: ctl_hit = 1'b0;
      default: ctl_hit = 1'b0;
    endcase
  end

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      ctl_we <= 1'b0;
      mod_we <= 1'b0;
      normal_we <= 1'b0;
      cpu_data_out <= '0;
    end else begin
      ctl_we <= wr_fire & ctl_hit;
      mod_we <= wr_fire & mod_hit;
      normal_we <= wr_fire & normal_hit;
      // only the controller bank can be read back
      if (~cs_n_q && we_n_q && ctl_hit) begin
        cpu_data_out <= ctl_rd_data;
      end else begin
        cpu_data_out <= '0;
      end
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    wr_addr <= addr_q[cpu_bus_pkg::BANK_ADDR_W-1:0];
    wr_data <= data_q;
  end

endmodule

// File: cpu_bus_pkg.sv
package cpu_bus_pkg;

  // host data bus
  localparam int BUS_DATA_W = 16;
  typedef logic [BUS_DATA_W-1:0] cpu_data_t;

  // the CPU address splits into a bank select and an address inside the bank
  localparam int BANK_SEL_W = 2;
  localparam int BANK_ADDR_W = 14;
  localparam int CPU_ADDR_W = BANK_SEL_W + BANK_ADDR_W;

  typedef logic [BANK_SEL_W-1:0] bank_sel_t;
  typedef logic [BANK_ADDR_W-1:0] bank_addr_t;

  localparam bank_sel_t BANK_CONTROLLER = 2'd0;
  localparam bank_sel_t BANK_MOD = 2'd1;
  localparam bank_sel_t BANK_NORMAL = 2'd2;
  localparam bank_sel_t BANK_STM = 2'd3;

  // controller register map
  localparam bank_addr_t ADDR_CTL_FLAG = 14'd0;
  localparam bank_addr_t ADDR_MOD_SEGMENT = 14'd1;
  localparam bank_addr_t ADDR_MOD_CYCLE = 14'd2;
  localparam bank_addr_t ADDR_MOD_FREQ_DIV = 14'd3;
  localparam bank_addr_t ADDR_VERSION = 14'd4;

  localparam cpu_data_t VERSION_NUM = 16'h0041;

  // bit positions in the control flag register
  localparam int CTL_FLAG_RUN_BIT = 0;

endpackage

// File: ctl_reg_file.sv
`timescale 1ns/100ps
module ctl_reg_file (
  input  logic                    CPU_CKIO,
  input  logic                    arst_n,
  input  logic                    ctl_we,
  input  cpu_bus_pkg::bank_addr_t wr_addr,
  input  cpu_bus_pkg::cpu_data_t  wr_data,
  input  cpu_bus_pkg::bank_addr_t rd_addr,
  output cpu_bus_pkg::cpu_data_t  rd_data,
  output logic                    run,
  output logic                    mod_segment,
  output drive_pkg::mod_idx_t     mod_cycle,
  output cpu_bus_pkg::cpu_data_t  mod_freq_div
);

  cpu_bus_pkg::cpu_data_t ctl_flag_q;
  cpu_bus_pkg::cpu_data_t mod_segment_q;
  cpu_bus_pkg::cpu_data_t mod_cycle_q;
  cpu_bus_pkg::cpu_data_t mod_freq_div_q;

  // full words are kept so the host reads back exactly what it wrote
  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      ctl_flag_q <= '0;
      mod_segment_q <= '0;
      mod_cycle_q <= '0;
      mod_freq_div_q <= '0;
    end else if (ctl_we) begin
      case (wr_addr)
        cpu_bus_pkg::ADDR_CTL_FLAG: begin
          ctl_flag_q <= wr_data;
        end
        cpu_bus_pkg::ADDR_MOD_SEGMENT: begin
          mod_segment_q <= wr_data;
        end
        cpu_bus_pkg::ADDR_MOD_CYCLE: begin
          mod_cycle_q <= wr_data;
        end
        cpu_bus_pkg::ADDR_MOD_FREQ_DIV: begin
          mod_freq_div_q <= wr_data;
        end
        default: begin
          ctl_flag_q <= ctl_flag_q;
        end
      endcase
    end
  end

  always_comb begin
    case (rd_addr)
      cpu_bus_pkg::ADDR_CTL_FLAG: begin
        rd_data = ctl_flag_q;
      end
      cpu_bus_pkg::ADDR_MOD_SEGMENT: begin
        rd_data = mod_segment_q;
      end
      cpu_bus_pkg::ADDR_MOD_CYCLE: begin
        rd_data = mod_cycle_q;
      end
      cpu_bus_pkg::ADDR_MOD_FREQ_DIV: begin
        rd_data = mod_freq_div_q;
      end
      cpu_bus_pkg::ADDR_VERSION: begin
        rd_data = cpu_bus_pkg::VERSION_NUM;
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  assign run = ctl_flag_q[cpu_bus_pkg::CTL_FLAG_RUN_BIT];
  assign mod_segment = mod_segment_q[0];
  // the cycle is the last valid sample index, so it fits the index width
  assign mod_cycle = mod_cycle_q[$bits(drive_pkg::mod_idx_t)-1:0];
  assign mod_freq_div = mod_freq_div_q;

endmodule

// File: drive_pkg.sv
package drive_pkg;

  localparam int NUM_TRANS = 8;
  typedef logic [$clog2(NUM_TRANS)-1:0] tr_idx_t;

  typedef logic [15:0] duty_t;
  typedef logic [15:0] phase_t;

  // modulation samples are bytes, packed two per host word
  typedef logic [7:0] mod_sample_t;

  localparam int MOD_DEPTH = 64;
  typedef logic [$clog2(MOD_DEPTH)-1:0] mod_idx_t;

  localparam int MOD_WORDS = 16;
  localparam int MOD_SEGMENTS = 2;
  typedef logic [$clog2(MOD_WORDS)-1:0] mod_word_addr_t;

  typedef enum logic {
    SEQ_IDLE,
    SEQ_SCAN
  } seq_state_t;

endpackage

// File: drive_stim.txt
# W bank addr data : host write, all hex
# R reg expected : controller read | E mod_idx duty_tr0 .. duty_tr7
R 0 0000
R 4 0041
W 0 1 0000
W 1 0 4080
W 0 1 0001
W 1 0 10FF
W 2 1 1000
W 2 3 2000
W 2 5 3000
W 2 7 4000
W 2 9 5000
W 2 B 6000
W 2 D 7000
W 2 F 8000
W 2 0 0A11
W 2 6 0B22
W 0 2 0021
W 0 3 0001
W 3 0 FFFF
W 0 7 1234
R 0 0000
R 1 0001
R 2 0021
R 3 0001
R 7 0000
E 0 0800 1000 1800 2000 2800 3000 3800 4000
E 1 0400 0800 0C00 1000 1400 1800 1C00 2000
E 20 0FF0 1FE0 2FD0 3FC0 4FB0 5FA0 6F90 7F80
E 21 0100 0200 0300 0400 0500 0600 0700 0800

// File: drive_top.sv
`timescale 1ns/100ps
module drive_top (
  input  logic                               CPU_CKIO,
  input  logic                               arst_n,
  input  logic                               cpu_cs_n,
  input  logic                               cpu_we_n,
  input  logic [cpu_bus_pkg::CPU_ADDR_W-1:0] cpu_addr,
  input  cpu_bus_pkg::cpu_data_t             cpu_data_in,
  output cpu_bus_pkg::cpu_data_t             cpu_data_out,
  output logic                               drive_valid,
  output drive_pkg::tr_idx_t                 drive_tr_idx,
  output drive_pkg::duty_t                   drive_duty,
  output drive_pkg::phase_t                  drive_phase,
  output drive_pkg::mod_idx_t                drive_mod_idx
);

  logic                    ctl_we;
  logic                    mod_we;
  logic                    normal_we;
  cpu_bus_pkg::bank_addr_t wr_addr;
  cpu_bus_pkg::cpu_data_t  wr_data;
  cpu_bus_pkg::bank_addr_t rd_addr;
  cpu_bus_pkg::cpu_data_t  ctl_rd_data;
  logic                    run;
  logic                    mod_segment;
  drive_pkg::mod_idx_t     mod_cycle;
  cpu_bus_pkg::cpu_data_t  mod_freq_div;
  drive_pkg::tr_idx_t      scan_tr;
  drive_pkg::mod_idx_t     scan_mod_idx;
  drive_pkg::mod_sample_t  sample;
  drive_pkg::duty_t        duty;
  drive_pkg::phase_t       phase;

  cpu_bus_decoder decoder_i (
    .CPU_CKIO(CPU_CKIO), .arst_n(arst_n), .cpu_cs_n(cpu_cs_n), .cpu_we_n(cpu_we_n),
    .cpu_addr(cpu_addr), .cpu_data_in(cpu_data_in), .ctl_rd_data(ctl_rd_data),
    .cpu_data_out(cpu_data_out), .ctl_we(ctl_we), .mod_we(mod_we), .normal_we(normal_we),
    .wr_addr(wr_addr), .wr_data(wr_data), .rd_addr(rd_addr)
  );

  ctl_reg_file ctl_i (
    .CPU_CKIO(CPU_CKIO), .arst_n(arst_n), .ctl_we(ctl_we), .wr_addr(wr_addr),
    .wr_data(wr_data), .rd_addr(rd_addr), .rd_data(ctl_rd_data), .run(run),
    .mod_segment(mod_segment), .mod_cycle(mod_cycle), .mod_freq_div(mod_freq_div)
  );

  mod_mem mod_i (
    .CPU_CKIO(CPU_CKIO), .mod_we(mod_we), .wr_addr(wr_addr), .wr_data(wr_data),
    .mod_segment(mod_segment), .rd_idx(scan_mod_idx), .rd_sample(sample)
  );

  duty_phase_mem normal_i (
    .CPU_CKIO(CPU_CKIO), .normal_we(normal_we), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_tr(scan_tr), .rd_duty(duty), .rd_phase(phase)
  );

  mod_sequencer seq_i (
    .CPU_CKIO(CPU_CKIO), .arst_n(arst_n), .run(run), .mod_cycle(mod_cycle),
    .mod_freq_div(mod_freq_div), .duty(duty), .phase(phase), .sample(sample),
    .scan_tr(scan_tr), .scan_mod_idx(scan_mod_idx), .drive_valid(drive_valid),
    .drive_tr_idx(drive_tr_idx), .drive_duty(drive_duty), .drive_phase(drive_phase),
    .drive_mod_idx(drive_mod_idx)
  );

endmodule

// File: drive_top_tb.sv
`timescale 1ns/100ps
module drive_top_tb;

  logic                   CPU_CKIO;
  logic                   arst_n;
  logic                   cpu_cs_n;
  logic                   cpu_we_n;
  logic [15:0]            cpu_addr;
  logic [15:0]            cpu_data_in;
  logic [15:0]            cpu_data_out;
  logic                   drive_valid;
  drive_pkg::tr_idx_t     drive_tr_idx;
  drive_pkg::duty_t       drive_duty;
  drive_pkg::phase_t      drive_phase;
  drive_pkg::mod_idx_t    drive_mod_idx;

  // reference model of what the host has written
  logic [15:0] ctl_m [4];
  logic [15:0] mod_m [32];
  logic [15:0] duty_m [8];
  logic [15:0] phase_m [8];
  logic [15:0] e_tab [64][8];
  logic        e_seen [64];

  int value_errs = 0;
  int timeout_errs = 0;
  int file_errs = 0;

  tb_clock_gen clk_i (.CPU_CKIO(CPU_CKIO), .arst_n(arst_n));

  drive_top dut_i (
    .CPU_CKIO(CPU_CKIO), .arst_n(arst_n), .cpu_cs_n(cpu_cs_n), .cpu_we_n(cpu_we_n),
    .cpu_addr(cpu_addr), .cpu_data_in(cpu_data_in), .cpu_data_out(cpu_data_out),
    .drive_valid(drive_valid), .drive_tr_idx(drive_tr_idx), .drive_duty(drive_duty),
    .drive_phase(drive_phase), .drive_mod_idx(drive_mod_idx)
  );

  function automatic logic [15:0] ctl_read(input logic [13:0] a);
    if (a < 14'd4) return ctl_m[a[1:0]];
    else if (a == 14'd4) return 16'h0041;
    else return 16'h0000;
  endfunction

  // sample k is byte k mod 2 of word k/2, the word index carrying the segment
  function automatic logic [15:0] scaled_duty(input logic [2:0] t, input logic [5:0] k);
    logic [15:0] w;
    logic [7:0]  s;
    logic [23:0] p;
    w = mod_m[k[5:1]];
    s = k[0] ? w[15:8] : w[7:0];
    p = {8'h00, duty_m[t]} * {16'h0000, s};
    return p[23:8];
  endfunction

  task automatic model_write(input logic [1:0] bank, input logic [13:0] a,
                             input logic [15:0] d);
    if (bank == 2'd0 && a < 14'd4) begin
      ctl_m[a[1:0]] = d;
    end else if (bank == 2'd1 && a < 14'd16) begin
      mod_m[{ctl_m[1][0], a[3:0]}] = d;
    end else if (bank == 2'd2 && a < 14'd16) begin
      if (a[0]) duty_m[a[3:1]] = d;
      else phase_m[a[3:1]] = d;
    end
  endtask

  task automatic bus_write(input logic [1:0] bank, input logic [13:0] a,
                           input logic [15:0] d);
    @(negedge CPU_CKIO);
    cpu_addr = {bank, a};
    cpu_data_in = d;
    cpu_cs_n = 1'b0;
    @(negedge CPU_CKIO);
    cpu_we_n = 1'b0;
    repeat (2) @(negedge CPU_CKIO);
    cpu_we_n = 1'b1;
    @(negedge CPU_CKIO);
    cpu_cs_n = 1'b1;
    model_write(bank, a, d);
  endtask

  task automatic bus_read_check(input logic [13:0] a, input logic [15:0] exp);
    @(negedge CPU_CKIO);
    cpu_addr = {2'd0, a};
    cpu_cs_n = 1'b0;
    cpu_we_n = 1'b1;
    repeat (2) @(posedge CPU_CKIO);
    @(negedge CPU_CKIO);
    assert (exp == ctl_read(a)) else begin
      value_errs++;
      $display("Fail at %0t: stim expects %h at reg %0d, model has %h",
               $time, exp, a, ctl_read(a));
    end
    assert (cpu_data_out == exp) else begin
      value_errs++;
      $display("Fail at %0t: reg %0d read %h, expected %h", $time, a, cpu_data_out, exp);
    end
    cpu_cs_n = 1'b1;
  endtask

  task automatic wait_valid(input logic level);
    int n;
    n = 0;
    while (drive_valid !== level && n < 100) begin
      @(negedge CPU_CKIO);
      n++;
    end
    if (drive_valid !== level) begin
      timeout_errs++;
      $display("timed out waiting for drive_valid to become %0b", level);
    end
  endtask

  // checks the stream one transducer per cycle from the current falling edge
  task automatic check_stream(input int cycles);
    logic [2:0]  tr_exp;
    logic [5:0]  idx_exp;
    logic [5:0]  cycle;
    logic [15:0] div_eff;
    logic [15:0] scans;
    tr_exp = 3'd0;
    idx_exp = 6'd0;
    scans = 16'd0;
    cycle = ctl_m[2][5:0];
    div_eff = (ctl_m[3] == 16'd0) ? 16'd1 : ctl_m[3];
    for (int k = 0; k < cycles; k++) begin
      assert (drive_valid && drive_tr_idx == tr_exp && drive_mod_idx == idx_exp) else begin
        value_errs++;
        $display("Fail at %0t: valid %0b tr %0d idx %0d, expected tr %0d idx %0d",
                 $time, drive_valid, drive_tr_idx, drive_mod_idx, tr_exp, idx_exp);
      end
      assert (drive_phase == phase_m[tr_exp]) else begin
        value_errs++;
        $display("Fail at %0t: phase %h for tr %0d, expected %h",
                 $time, drive_phase, tr_exp, phase_m[tr_exp]);
      end
      assert (drive_duty == scaled_duty(tr_exp, idx_exp)) else begin
        value_errs++;
        $display("Fail at %0t: duty %h for tr %0d idx %0d, expected %h",
                 $time, drive_duty, tr_exp, idx_exp, scaled_duty(tr_exp, idx_exp));
      end
      assert (!e_seen[idx_exp] || drive_duty == e_tab[idx_exp][tr_exp]) else begin
        value_errs++;
        $display("Fail at %0t: duty %h for tr %0d idx %0d, stim expects %h",
                 $time, drive_duty, tr_exp, idx_exp, e_tab[idx_exp][tr_exp]);
      end
      if (tr_exp == 3'd7) begin
        scans = scans + 16'd1;
        if (scans == div_eff) begin
          scans = 16'd0;
          idx_exp = (idx_exp == cycle) ? 6'd0 : idx_exp + 6'd1;
        end
      end
      tr_exp = tr_exp + 3'd1;
      @(negedge CPU_CKIO);
    end
  endtask

  task automatic run_stim_file();
    int          fd;
    int          code;
    string       line;
    logic [15:0] f0;
    logic [15:0] f1;
    logic [15:0] f2;
    logic [15:0] ev [8];
    fd = $fopen("drive_stim.txt", "r");
    if (fd == 0) begin
      file_errs++;
      $display("could not open drive_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code > 1 && line[0] == "W") begin
          code = $sscanf(line, "W %h %h %h", f0, f1, f2);
          bus_write(f0[1:0], f1[13:0], f2);
        end else if (code > 1 && line[0] == "R") begin
          code = $sscanf(line, "R %h %h", f0, f1);
          bus_read_check(f0[13:0], f1);
        end else if (code > 1 && line[0] == "E") begin
          code = $sscanf(line, "E %h %h %h %h %h %h %h %h %h", f0,
                         ev[0], ev[1], ev[2], ev[3], ev[4], ev[5], ev[6], ev[7]);
          e_seen[f0[5:0]] = 1'b1;
          for (int t = 0; t < 8; t++) begin
            e_tab[f0[5:0]][t] = ev[t];
            assert (ev[t] == scaled_duty(3'(t), f0[5:0])) else begin
              value_errs++;
              $display("Fail at %0t: stim duty %h for tr %0d idx %0d, model gives %h",
                       $time, ev[t], t, f0[5:0], scaled_duty(3'(t), f0[5:0]));
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  initial begin
    int total;
    cpu_cs_n = 1'b1;
    cpu_we_n = 1'b1;
    cpu_addr = 16'h0000;
    cpu_data_in = 16'h0000;
    for (int i = 0; i < 4; i++) ctl_m[i] = 16'h0000;
    for (int i = 0; i < 32; i++) mod_m[i] = 16'h0000;
    for (int i = 0; i < 8; i++) begin
      duty_m[i] = 16'h0000;
      phase_m[i] = 16'h0000;
    end
    for (int i = 0; i < 64; i++) e_seen[i] = 1'b0;

    for (int n = 0; n < 20 && arst_n !== 1'b1; n++) @(negedge CPU_CKIO);
    if (arst_n !== 1'b1) begin
      timeout_errs++;
      $display("timed out waiting for reset release");
    end
    @(negedge CPU_CKIO);
    assert (drive_valid == 1'b0) else begin
      value_errs++;
      $display("Fail at %0t: drive_valid high after reset", $time);
    end
    assert (cpu_data_out == 16'h0000) else begin
      value_errs++;
      $display("Fail at %0t: cpu_data_out %h after reset, expected 0000",
               $time, cpu_data_out);
    end

    // the remaining writable registers also come out of reset cleared
    for (int a = 1; a < 4; a++) begin
      bus_read_check(14'(a), 16'h0000);
    end

    run_stim_file();

    // full pass through all modulation indices and one wrap
    bus_write(2'd0, 14'd0, 16'h0001);
    wait_valid(1'b1);
    check_stream((int'(ctl_m[2][5:0]) + 1) * int'(ctl_m[3]) * 8 + 16);

    // stop, then restart from transducer 0 and index 0 with the index held for three scans
    bus_write(2'd0, 14'd0, 16'h0000);
    wait_valid(1'b0);
    bus_write(2'd0, 14'd3, 16'h0003);
    bus_write(2'd0, 14'd0, 16'h0001);
    wait_valid(1'b1);
    check_stream(80);

    total = value_errs + timeout_errs + file_errs;
    $display("errors: %0d value, %0d timeout, %0d file", value_errs, timeout_errs, file_errs);
    if (total == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: duty_phase_mem.sv
`timescale 1ns/100ps
module duty_phase_mem (
  input  logic                    CPU_CKIO,
  input  logic                    normal_we,
  input  cpu_bus_pkg::bank_addr_t wr_addr,
  input  cpu_bus_pkg::cpu_data_t  wr_data,
  input  drive_pkg::tr_idx_t      rd_tr,
  output drive_pkg::duty_t        rd_duty,
  output drive_pkg::phase_t       rd_phase
);

  drive_pkg::duty_t  duty_mem [drive_pkg::NUM_TRANS];
  drive_pkg::phase_t phase_mem [drive_pkg::NUM_TRANS];

  drive_pkg::tr_idx_t wr_tr;
  logic               wr_in_range;

  initial begin
    for (int i = 0; i < drive_pkg::NUM_TRANS; i++) begin
      duty_mem[i] = '0;
      phase_mem[i] = '0;
    end
  end

  assign wr_tr = wr_addr[$bits(drive_pkg::tr_idx_t):1];
  assign wr_in_range = (wr_addr < cpu_bus_pkg::bank_addr_t'(2 * drive_pkg::NUM_TRANS));

  // odd addresses carry the duty, even ones the phase
  always_ff @(posedge CPU_CKIO) begin
    if (normal_we && wr_in_range) begin
      if (wr_addr[0]) begin
        duty_mem[wr_tr] <= wr_data;
      end else begin
        phase_mem[wr_tr] <= wr_data;
      end
    end
  end

  assign rd_duty = duty_mem[rd_tr];
  assign rd_phase = phase_mem[rd_tr];

endmodule

// File: mod_mem.sv
`timescale 1ns/100ps
module mod_mem (
  input  logic                    CPU_CKIO,
  input  logic                    mod_we,
  input  cpu_bus_pkg::bank_addr_t wr_addr,
  input  cpu_bus_pkg::cpu_data_t  wr_data,
  input  logic                    mod_segment,
  input  drive_pkg::mod_idx_t     rd_idx,
  output drive_pkg::mod_sample_t  rd_sample
);

  localparam int WORD_AW = $bits(drive_pkg::mod_word_addr_t) + 1;

  cpu_bus_pkg::cpu_data_t mem [drive_pkg::MOD_SEGMENTS * drive_pkg::MOD_WORDS];

  drive_pkg::mod_word_addr_t wr_word;
  logic                      wr_in_range;
  logic [WORD_AW-1:0]        rd_word;
  cpu_bus_pkg::cpu_data_t    rd_pair;

  // contents start cleared
  initial begin
    for (int i = 0; i < drive_pkg::MOD_SEGMENTS * drive_pkg::MOD_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  assign wr_word = wr_addr[$bits(drive_pkg::mod_word_addr_t)-1:0];
  assign wr_in_range = (wr_addr < cpu_bus_pkg::bank_addr_t'(drive_pkg::MOD_WORDS));

  always_ff @(posedge CPU_CKIO) begin
    if (mod_we && wr_in_range) begin
      mem[{mod_segment, wr_word}] <= wr_data;
    end
  end

  // sample k sits in word k/2 across both segments, even samples in the low byte
  assign rd_word = rd_idx[$bits(drive_pkg::mod_idx_t)-1:1];
  assign rd_pair = mem[rd_word];
  assign rd_sample = rd_idx[0] ? rd_pair[15:8] : rd_pair[7:0];

endmodule

// File: mod_sequencer.sv
`timescale 1ns/100ps
module mod_sequencer (
  input  logic                   CPU_CKIO,
  input  logic                   arst_n,
  input  logic                   run,
  input  drive_pkg::mod_idx_t    mod_cycle,
  input  cpu_bus_pkg::cpu_data_t mod_freq_div,
  input  drive_pkg::duty_t       duty,
  input  drive_pkg::phase_t      phase,
  input  drive_pkg::mod_sample_t sample,
  output drive_pkg::tr_idx_t     scan_tr,
  output drive_pkg::mod_idx_t    scan_mod_idx,
  output logic                   drive_valid,
  output drive_pkg::tr_idx_t     drive_tr_idx,
  output drive_pkg::duty_t       drive_duty,
  output drive_pkg::phase_t      drive_phase,
  output drive_pkg::mod_idx_t    drive_mod_idx
);

  localparam int PROD_W = $bits(drive_pkg::duty_t) + $bits(drive_pkg::mod_sample_t);

  drive_pkg::seq_state_t  state;
  cpu_bus_pkg::cpu_data_t scan_cnt;
  cpu_bus_pkg::cpu_data_t scan_cnt_next;
  logic                   last_tr;
  logic [PROD_W-1:0]      product;

  assign last_tr = (scan_tr == drive_pkg::tr_idx_t'(drive_pkg::NUM_TRANS - 1));
  assign scan_cnt_next = scan_cnt + 1'b1;
  assign product = duty * sample;

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      state <= drive_pkg::SEQ_IDLE;
      scan_tr <= '0;
      scan_mod_idx <= '0;
      scan_cnt <= '0;
      drive_valid <= 1'b0;
      drive_tr_idx <= '0;
      drive_duty <= '0;
      drive_phase <= '0;
      drive_mod_idx <= '0;
    end else begin
      case (state)
        drive_pkg::SEQ_IDLE: begin
          drive_valid <= 1'b0;
          drive_tr_idx <= '0;
          drive_mod_idx <= '0;
          scan_tr <= '0;
          scan_mod_idx <= '0;
          scan_cnt <= '0;
          if (run) begin
            state <= drive_pkg::SEQ_SCAN;
          end
        end
        drive_pkg::SEQ_SCAN: begin
          if (!run) begin
            state <= drive_pkg::SEQ_IDLE;
            drive_valid <= 1'b0;
            drive_tr_idx <= '0;
            drive_mod_idx <= '0;
            scan_tr <= '0;
            scan_mod_idx <= '0;
            scan_cnt <= '0;
          end else begin
            drive_valid <= 1'b1;
            drive_tr_idx <= scan_tr;
            drive_duty <= product[PROD_W-1:8];
            drive_phase <= phase;
            drive_mod_idx <= scan_mod_idx;
            scan_tr <= scan_tr + 1'b1;
            // a divider of 0 behaves like 1
            if (last_tr) begin
              if (scan_cnt_next >= mod_freq_div) begin
                scan_cnt <= '0;
                scan_mod_idx <= (scan_mod_idx >= mod_cycle) ? '0 : scan_mod_idx + 1'b1;
              end else begin
                scan_cnt <= scan_cnt_next;
              end
            end
          end
        end
        default: begin
          state <= drive_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/100ps
module tb_clock_gen (
  output logic CPU_CKIO,
  output logic arst_n
);

  initial begin
    CPU_CKIO = 1'b0;
    forever #4 CPU_CKIO = ~CPU_CKIO;
  end

  // reset is released on a falling edge, away from the sampling edge
  initial begin
    arst_n = 1'b0;
    repeat (2) @(posedge CPU_CKIO);
    @(negedge CPU_CKIO);
    arst_n = 1'b1;
  end

endmodule
